//--- verilog/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// pc and wishbone address width
`define FETCH_ADDR_W 64

// wishbone data width, one doubleword per beat
`define FETCH_DATA_W 64

// one uncompressed instruction
`define FETCH_INS_W 32

// on-chip ram size in doublewords
`define FETCH_RAM_DEPTH 256

// first fetch address after reset
`define FETCH_RESET_PC 64'h0

`endif

//--- verilog/fetch_pkg.sv
`include "fetch_cfg.svh"

package fetch_pkg;

	// master to slave, wishbone classic
	typedef struct packed {
		logic [`FETCH_ADDR_W-1:0]   adr;
		logic [`FETCH_DATA_W-1:0]   dat_w;
		// one enable per byte lane
		logic [`FETCH_DATA_W/8-1:0] sel;
		logic                       we;
		logic                       cyc;
		logic                       stb;
	} wb_req_t;

	// slave to master
	typedef struct packed {
		// only meaningful while ack is high
		logic [`FETCH_DATA_W-1:0] dat_r;
		logic                     ack;
	} wb_rsp_t;

	// one fetched instruction for the next stage
	typedef struct packed {
		logic [`FETCH_ADDR_W-1:0] pc;
		// sequential successor, pc + 4
		logic [`FETCH_ADDR_W-1:0] snpc;
		logic [`FETCH_INS_W-1:0]  ins;
	} fetch_out_t;

	// branch redirect from the back end
	typedef struct packed {
		logic                     valid;
		logic [`FETCH_ADDR_W-1:0] target;
	} redirect_t;

	// load or store from execute
	typedef struct packed {
		// doubleword address, low bits ignored
		logic [`FETCH_ADDR_W-1:0]   addr;
		logic [`FETCH_DATA_W-1:0]   wdata;
		logic [`FETCH_DATA_W/8-1:0] sel;
		logic                       we;
	} data_req_t;

endpackage

//--- verilog/pc_gen.sv
`include "fetch_cfg.svh"

module pc_gen (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     advance,
	input  fetch_pkg::redirect_t     redirect,
	output logic [`FETCH_ADDR_W-1:0] pc
);
	import fetch_pkg::*;

	// sequential step, one instruction
	localparam logic [`FETCH_ADDR_W-1:0] ins_step = 4;

	// registered fetch pc
	logic [`FETCH_ADDR_W-1:0] pc_q;

	// redirect seen between two advances
	redirect_t pend_q;

	// a pending redirect takes over the fetch address at once
	// so the next fetch goes straight to the target
	assign pc = pend_q.valid ? pend_q.target : pc_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc_q <= `FETCH_RESET_PC;
			pend_q <= '0;
		end else if (advance) begin
			// fetch issued this cycle at pc
			if (redirect.valid) begin
				// that fetch is wrong path, ifetch drops it
				pc_q <= redirect.target;
			end else begin
				pc_q <= pc + ins_step;
			end
			// pending target consumed by this fetch
			pend_q.valid <= 1'b0;
		end else if (redirect.valid) begin
			// no fetch this cycle, keep newest target
			pend_q <= redirect;
		end
	end

endmodule

//--- verilog/ifetch.sv
`include "fetch_cfg.svh"

module ifetch (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     fetch_enable,
	input  logic [`FETCH_ADDR_W-1:0] pc,
	output logic                     advance,
	input  fetch_pkg::redirect_t     redirect,
	output fetch_pkg::wb_req_t       f_req,
	input  fetch_pkg::wb_rsp_t       f_rsp,
	output fetch_pkg::fetch_out_t    out,
	output logic                     out_valid,
	input  logic                     out_ready
);
	import fetch_pkg::*;

	localparam logic [`FETCH_ADDR_W-1:0] ins_step = 4;

	// bus side
	logic                     busy_q;
	logic                     stale_q;
	logic [`FETCH_ADDR_W-1:0] req_pc_q;

	// holding buffer behind the bus
	logic       hold_valid_q;
	fetch_out_t hold_q;

	logic                    issue;
	logic                    fetch_done;
	logic                    keep;
	logic                    out_free;
	logic [`FETCH_INS_W-1:0] ins_sel;
	fetch_out_t              rsp_item;

	// output slot empty or draining this cycle
	assign out_free = !out_valid || out_ready;

	// one fetch at a time, none while the buffer is occupied
	assign issue = fetch_enable && !busy_q && !hold_valid_q;
	assign advance = issue;

	assign fetch_done = busy_q && f_rsp.ack;

	// data returning in a redirect cycle is wrong path as well
	assign keep = fetch_done && !stale_q && !redirect.valid;

	// bit 2 picks the upper word of the doubleword
	assign ins_sel = req_pc_q[2] ? f_rsp.dat_r[`FETCH_DATA_W-1 -: `FETCH_INS_W]
		: f_rsp.dat_r[`FETCH_INS_W-1:0];

	always_comb begin
		rsp_item.pc = req_pc_q;
		rsp_item.snpc = req_pc_q + ins_step;
		rsp_item.ins = ins_sel;
	end

	// read only, doubleword aligned
	always_comb begin
		f_req.adr = {req_pc_q[`FETCH_ADDR_W-1:3], 3'b000};
		f_req.dat_w = '0;
		f_req.sel = '1;
		f_req.we = 1'b0;
		f_req.cyc = busy_q;
		f_req.stb = busy_q;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy_q <= 1'b0;
			stale_q <= 1'b0;
			hold_valid_q <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			// cyc drops for a cycle after ack so the arbiter can switch
			if (issue) begin
				busy_q <= 1'b1;
			end else if (fetch_done) begin
				busy_q <= 1'b0;
			end
			// mark the fetch on the bus, or the one issued now
			if (fetch_done) begin
				stale_q <= 1'b0;
			end else if (redirect.valid && (busy_q || issue)) begin
				stale_q <= 1'b1;
			end
			// redirect flushes both buffered items
			if (redirect.valid) begin
				out_valid <= 1'b0;
				hold_valid_q <= 1'b0;
			end else if (out_free) begin
				// older buffered item goes first
				out_valid <= hold_valid_q || keep;
				hold_valid_q <= 1'b0;
			end else if (keep) begin
				hold_valid_q <= 1'b1;
			end
		end
	end

	// payload only, qualified by the valid flags above
	always_ff @(posedge clk) begin
		if (issue) begin
			req_pc_q <= pc;
		end
		if (keep && !out_free) begin
			hold_q <= rsp_item;
		end
		if (out_free) begin
			if (hold_valid_q) begin
				out <= hold_q;
			end else if (keep) begin
				out <= rsp_item;
			end
		end
	end

	// stalled output must not change or vanish unless flushed
	a_out_stable: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready && !redirect.valid |=> out_valid && $stable(out));

endmodule

//--- verilog/lsu_port.sv
`include "fetch_cfg.svh"

module lsu_port (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     dreq_valid,
	input  fetch_pkg::data_req_t     dreq,
	output logic                     drsp_done,
	output logic [`FETCH_DATA_W-1:0] rdata,
	output fetch_pkg::wb_req_t       d_req,
	input  fetch_pkg::wb_rsp_t       d_rsp
);
	import fetch_pkg::*;

	// cycle on the bus
	logic busy_q;
	// request served, waiting for execute to drop dreq_valid
	logic wait_q;
	// captured request, held for the whole cycle
	data_req_t req_q;

	logic start;
	logic ack_hit;

	assign start = dreq_valid && !busy_q && !wait_q;
	assign ack_hit = busy_q && d_rsp.ack;

	always_comb begin
		// misaligned accesses are not supported
		d_req.adr = {req_q.addr[`FETCH_ADDR_W-1:3], 3'b000};
		d_req.dat_w = req_q.wdata;
		d_req.sel = req_q.sel;
		d_req.we = req_q.we;
		d_req.cyc = busy_q;
		d_req.stb = busy_q;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy_q <= 1'b0;
			wait_q <= 1'b0;
			drsp_done <= 1'b0;
		end else begin
			// one cycle pulse, the cycle after ack
			drsp_done <= ack_hit;
			if (start) begin
				busy_q <= 1'b1;
			end else if (ack_hit) begin
				busy_q <= 1'b0;
			end
			// the same request is still held during drsp_done
			if (ack_hit) begin
				wait_q <= 1'b1;
			end else if (!dreq_valid) begin
				wait_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			req_q <= dreq;
		end
		// read data, garbage for stores
		if (ack_hit) begin
			rdata <= d_rsp.dat_r;
		end
	end

endmodule

//--- verilog/wb_arbiter.sv
`include "fetch_cfg.svh"

module wb_arbiter (
	input  logic               clk,
	input  logic               reset,
	input  fetch_pkg::wb_req_t f_req,
	input  fetch_pkg::wb_req_t d_req,
	output fetch_pkg::wb_rsp_t f_rsp,
	output fetch_pkg::wb_rsp_t d_rsp,
	output fetch_pkg::wb_req_t m_req,
	input  fetch_pkg::wb_rsp_t m_rsp
);
	import fetch_pkg::*;

	// a master owns the bus
	logic locked_q;
	// owner is the data master
	logic gnt_d_q;

	logic keep_gnt;
	logic gnt_d;

	// owner keeps the bus as long as its cyc stays up
	assign keep_gnt = locked_q && (gnt_d_q ? d_req.cyc : f_req.cyc);

	// free bus goes to data first, else to fetch
	assign gnt_d = keep_gnt ? gnt_d_q : d_req.cyc;

	// request mux toward the slave
	assign m_req = gnt_d ? d_req : f_req;

	always_comb begin
		// read data is broadcast, ack is steered
		f_rsp.dat_r = m_rsp.dat_r;
		d_rsp.dat_r = m_rsp.dat_r;
		f_rsp.ack = m_rsp.ack && !gnt_d;
		d_rsp.ack = m_rsp.ack && gnt_d;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			locked_q <= 1'b0;
			gnt_d_q <= 1'b0;
		end else begin
			// lock follows the cyc of whoever is granted now
			locked_q <= m_req.cyc;
			gnt_d_q <= gnt_d;
		end
	end

	// ack goes back to the master whose request earned it
	a_ack_owner: assert property (@(posedge clk) disable iff (reset)
		m_rsp.ack |-> $past(m_req.cyc) && (gnt_d == $past(gnt_d)));

endmodule

//--- verilog/wb_ram.sv
`include "fetch_cfg.svh"

module wb_ram (
	input  logic               clk,
	input  logic               reset,
	input  fetch_pkg::wb_req_t m_req,
	output fetch_pkg::wb_rsp_t m_rsp
);
	import fetch_pkg::*;

	// doubleword index width
	localparam int idx_w = $clog2(`FETCH_RAM_DEPTH);

	logic [`FETCH_DATA_W-1:0] mem [0:`FETCH_RAM_DEPTH-1];

	logic [idx_w-1:0]         idx;
	logic                     take;
	logic                     ack_q;
	logic [`FETCH_DATA_W-1:0] rdata_q;

	// bits above the byte offset, upper address bits alias
	assign idx = m_req.adr[idx_w+2:3];

	// new access sampled; not again in its own ack cycle
	assign take = m_req.cyc && m_req.stb && !ack_q;

	always_comb begin
		m_rsp.dat_r = rdata_q;
		m_rsp.ack = ack_q;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= take;
		end
	end

	// write and read at the sampling edge, old data for a write
	always_ff @(posedge clk) begin
		if (take) begin
			if (m_req.we) begin
				for (int b = 0; b < `FETCH_DATA_W / 8; b++) begin
					if (m_req.sel[b]) begin
						mem[idx][b*8 +: 8] <= m_req.dat_w[b*8 +: 8];
					end
				end
			end
			rdata_q <= mem[idx];
		end
	end

	// ack only while the sampled request is still held on the bus
	a_ack_req_held: assert property (@(posedge clk) disable iff (reset)
		m_rsp.ack |-> m_req.cyc && m_req.stb && $stable(m_req.adr) && $stable(m_req.we));

endmodule

//--- verilog/fetch_top.sv
`include "fetch_cfg.svh"

module fetch_top (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     fetch_enable,
	input  fetch_pkg::redirect_t     redirect,
	output fetch_pkg::fetch_out_t    out,
	output logic                     out_valid,
	input  logic                     out_ready,
	input  logic                     dreq_valid,
	input  fetch_pkg::data_req_t     dreq,
	output logic                     drsp_done,
	output logic [`FETCH_DATA_W-1:0] rdata
);
	import fetch_pkg::*;

	logic [`FETCH_ADDR_W-1:0] pc;
	logic                     advance;

	// fetch master, data master, shared slave
	wb_req_t f_req;
	wb_req_t d_req;
	wb_req_t m_req;
	wb_rsp_t f_rsp;
	wb_rsp_t d_rsp;
	wb_rsp_t m_rsp;

	pc_gen u_pc_gen (
		.clk      (clk),
		.reset    (reset),
		.advance  (advance),
		.redirect (redirect),
		.pc       (pc)
	);

	ifetch u_ifetch (
		.clk          (clk),
		.reset        (reset),
		.fetch_enable (fetch_enable),
		.pc           (pc),
		.advance      (advance),
		.redirect     (redirect),
		.f_req        (f_req),
		.f_rsp        (f_rsp),
		.out          (out),
		.out_valid    (out_valid),
		.out_ready    (out_ready)
	);

	lsu_port u_lsu_port (
		.clk        (clk),
		.reset      (reset),
		.dreq_valid (dreq_valid),
		.dreq       (dreq),
		.drsp_done  (drsp_done),
		.rdata      (rdata),
		.d_req      (d_req),
		.d_rsp      (d_rsp)
	);

	// data side wins a free bus
	wb_arbiter u_wb_arbiter (
		.clk   (clk),
		.reset (reset),
		.f_req (f_req),
		.d_req (d_req),
		.f_rsp (f_rsp),
		.d_rsp (d_rsp),
		.m_req (m_req),
		.m_rsp (m_rsp)
	);

	wb_ram u_wb_ram (
		.clk   (clk),
		.reset (reset),
		.m_req (m_req),
		.m_rsp (m_rsp)
	);

endmodule

//--- test/fetch_tb.sv
`include "fetch_cfg.svh"

module fetch_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import fetch_pkg::*;

	localparam int ram_words = `FETCH_RAM_DEPTH;
	localparam int idx_w = $clog2(ram_words);
	// cycles allowed for one data access
	localparam int wait_limit = 100;

	logic                     clk = 1'b0;
	logic                     reset;
	logic                     fetch_enable;
	redirect_t                redirect;
	fetch_out_t               out;
	logic                     out_valid;
	logic                     out_ready;
	logic                     dreq_valid;
	data_req_t                dreq;
	logic                     drsp_done;
	logic [`FETCH_DATA_W-1:0] rdata;

	// mirror of the ram contents
	logic [`FETCH_DATA_W-1:0] model [0:ram_words-1];
	// pc of the next instruction the stream should deliver
	logic [`FETCH_ADDR_W-1:0] model_pc;
	logic [31:0]              lfsr;
	int                       errors;
	int                       accepted;
	int                       test_start;
	// output was stalled at the last sample
	logic                     stalled;
	fetch_out_t               held;

	fetch_top uut (
		.clk          (clk),
		.reset        (reset),
		.fetch_enable (fetch_enable),
		.redirect     (redirect),
		.out          (out),
		.out_valid    (out_valid),
		.out_ready    (out_ready),
		.dreq_valid   (dreq_valid),
		.dreq         (dreq),
		.drsp_done    (drsp_done),
		.rdata        (rdata)
	);

	always #20 clk = ~clk;

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r = {r[62:0], fb};
		end
		return r;
	endfunction

	// bit 2 picks the upper word of the doubleword
	function automatic logic [31:0] model_ins(input logic [63:0] pc);
		logic [63:0] dw;
		dw = model[pc[idx_w+2:3]];
		return pc[2] ? dw[63:32] : dw[31:0];
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		$display("Fail %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
		errors++;
	endtask

	// fetch stream checker, mid cycle so all registers have settled
	always @(negedge clk) begin
		if (!reset) begin
			if (stalled && !out_valid) begin
				$display("stalled instruction vanished without a redirect at %0t", $time);
				errors++;
			end
			if (stalled && out_valid && out.pc != held.pc) begin
				report_mismatch("out.pc (stall)", out.pc, held.pc);
			end
			if (stalled && out_valid && out.snpc != held.snpc) begin
				report_mismatch("out.snpc (stall)", out.snpc, held.snpc);
			end
			if (stalled && out_valid && out.ins != held.ins) begin
				report_mismatch("out.ins (stall)", 64'(out.ins), 64'(held.ins));
			end
			if (out_valid && out_ready) begin
				if (out.pc != model_pc) begin
					report_mismatch("out.pc", out.pc, model_pc);
				end
				if (out.ins != model_ins(model_pc)) begin
					report_mismatch("out.ins", 64'(out.ins), 64'(model_ins(model_pc)));
				end
				if (out.snpc != model_pc + 4) begin
					report_mismatch("out.snpc", out.snpc, model_pc + 4);
				end
				// sequential successor in the model stream
				model_pc = model_pc + 4;
				accepted++;
			end
			// a redirect overrides whatever came before it
			if (redirect.valid) begin
				model_pc = redirect.target;
			end
			stalled = out_valid && !out_ready && !redirect.valid;
			held = out;
		end
	end

	// one request on the data port, held until done
	task automatic data_access(input logic we, input int idx, input logic [63:0] wdata,
		input logic [7:0] sel, output logic [63:0] result);
		int n;
		n = 0;
		@(posedge clk);
		dreq_valid <= 1'b1;
		dreq.addr <= 64'(idx) << 3;
		dreq.wdata <= wdata;
		dreq.sel <= sel;
		dreq.we <= we;
		do begin
			@(negedge clk);
			n++;
		end while (!drsp_done && n < wait_limit);
		if (!drsp_done) begin
			$display("timeout, data port never signalled done at %0t", $time);
			errors++;
		end
		result = rdata;
		// byte merge into the mirror once the store is done
		if (we && drsp_done) begin
			for (int b = 0; b < 8; b++) begin
				if (sel[b]) begin
					model[idx][b*8 +: 8] = wdata[b*8 +: 8];
				end
			end
		end
		@(posedge clk);
		dreq_valid <= 1'b0;
	endtask

	task automatic store_and_check(input int idx, input logic [63:0] wdata,
		input logic [7:0] sel);
		logic [63:0] got;
		data_access(1'b1, idx, wdata, sel, got);
		data_access(1'b0, idx, '0, 8'hff, got);
		if (got != model[idx]) begin
			report_mismatch("rdata", got, model[idx]);
		end
	endtask

	// let the stream run until count more instructions are taken
	task automatic run_fetch(input int count, input logic ready_rand, input logic redir_rand);
		int goal;
		int n;
		goal = accepted + count;
		n = 0;
		while (accepted < goal && n < count * 40) begin
			@(posedge clk);
			n++;
			out_ready <= ready_rand ? 1'(rand_bits(1)) : 1'b1;
			// about one redirect in sixteen cycles
			if (redir_rand && rand_bits(4) == 0) begin
				redirect.valid <= 1'b1;
				redirect.target <= rand_bits(9) << 2;
			end else begin
				redirect.valid <= 1'b0;
			end
		end
		@(posedge clk);
		out_ready <= 1'b1;
		redirect <= '0;
		if (accepted < goal) begin
			$display("timeout, only %0d of %0d instructions arrived", count - (goal - accepted),
				count);
			errors++;
		end
	endtask

	task automatic close_test(input string name);
		$display("%s done, %0d errors", name, errors - test_start);
		test_start = errors;
	endtask

	initial begin
		logic [63:0] got;
		reset = 1'b1;
		fetch_enable = 1'b0;
		redirect = '0;
		out_ready = 1'b1;
		dreq_valid = 1'b0;
		dreq = '0;
		lfsr = 32'h1ce3eb95;
		errors = 0;
		accepted = 0;
		test_start = 0;
		stalled = 1'b0;
		model_pc = `FETCH_RESET_PC;
		repeat (10) @(posedge clk);
		reset <= 1'b0;

		// fill every doubleword through the data port, pattern from the full index
		for (int i = 0; i < ram_words; i++) begin
			data_access(1'b1, i, {32'(i) * 32'h9e3779b1, 32'(i) ^ 32'h6b2c0f00}, 8'hff, got);
		end

		for (int i = 0; i < 64; i++) begin
			store_and_check(int'(rand_bits(idx_w)), rand_bits(64), 8'hff);
		end
		close_test("data port stores");

		for (int i = 0; i < 32; i++) begin
			store_and_check(int'(rand_bits(idx_w)), rand_bits(64), 8'(rand_bits(8)));
		end
		close_test("data port byte writes");

		@(posedge clk);
		fetch_enable <= 1'b1;
		run_fetch(200, 1'b0, 1'b0);
		close_test("sequential fetch");

		run_fetch(200, 1'b1, 1'b0);
		close_test("back-pressure");

		run_fetch(200, 1'b1, 1'b1);
		close_test("redirect");

		// stores land well ahead of the fetch window
		for (int i = 0; i < 16; i++) begin
			store_and_check((int'(model_pc[idx_w+2:3]) + 16 + int'(rand_bits(4))) % ram_words,
				rand_bits(64), 8'(rand_bits(8)));
		end
		run_fetch(160, 1'b0, 1'b0);
		close_test("shared bus");

		$display("all tests done, %0d errors, %0d instructions checked", errors, accepted);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

//--- src.f
+incdir+verilog
verilog/fetch_pkg.sv
verilog/pc_gen.sv
verilog/ifetch.sv
verilog/lsu_port.sv
verilog/wb_arbiter.sv
verilog/wb_ram.sv
verilog/fetch_top.sv
test/fetch_tb.sv
